// ==== dv/sys_core_tb.sv ====
// Testbench for the system shell core
// Applies a table of user-I/O commands, aspect ratios and audio samples and
// checks the window, LED and audio outputs against reference models

`timescale 1ns/1ps
`default_nettype none

module sys_core_tb;

	typedef struct packed {
		sys_pkg::io_word_t [11:0] words;
		logic [3:0]               nw;
		logic [3:0]               brk;
		sys_pkg::aspect_t         arx;
		sys_pkg::aspect_t         ary;
		sys_pkg::led_t            led_core;
		sys_pkg::sample_t         core_l;
		sys_pkg::sample_t         core_r;
		sys_pkg::sample_t         alsa_l;
		sys_pkg::sample_t         alsa_r;
		sys_pkg::mix_mode_t       mix;
		logic                     sgn;
		sys_pkg::timing_t         hmin;
		sys_pkg::timing_t         hmax;
		sys_pkg::timing_t         vmin;
		sys_pkg::timing_t         vmax;
		sys_pkg::led_t            led;
		sys_pkg::sample_t         out_l;
		sys_pkg::sample_t         out_r;
	} test_row_t;

	logic               clk_sys;
	logic               resetd;
	logic               i_io_uio;
	logic               i_io_strobe;
	sys_pkg::io_word_t  i_io_din;
	sys_pkg::aspect_t   i_arx;
	sys_pkg::aspect_t   i_ary;
	sys_pkg::led_t      i_led_core;
	sys_pkg::sample_t   i_audio_l;
	sys_pkg::sample_t   i_audio_r;
	sys_pkg::sample_t   i_alsa_l;
	sys_pkg::sample_t   i_alsa_r;
	logic               i_audio_signed;
	sys_pkg::mix_mode_t i_audio_mix;
	sys_pkg::timing_t   o_hmin;
	sys_pkg::timing_t   o_hmax;
	sys_pkg::timing_t   o_vmin;
	sys_pkg::timing_t   o_vmax;
	sys_pkg::led_t      o_led;
	sys_pkg::sample_t   o_audio_l;
	sys_pkg::sample_t   o_audio_r;

	// Stimulus table and the register model used to fill it
	test_row_t         row;
	test_row_t         table_q[$];
	string             name_q[$];
	sys_pkg::io_word_t word_q[$];
	int                m_width  = 1920;
	int                m_height = 1080;
	int                m_vset   = 0;
	sys_pkg::att_t     m_att    = '0;
	sys_pkg::led_t     m_mask   = '0;
	sys_pkg::led_t     m_state  = '0;
	integer            seed     = 32'h2d59_2e57;
	int                fail_cnt = 0;
	int                bad_tests = 0;

	sys_core_top dut_i (.*);

	initial clk_sys = 1'b0;
	always #10 clk_sys = ~clk_sys;

	//////////////////////////////
	// Reference models
	//////////////////////////////

	// Converted core sample plus Linux sample
	function automatic int conv_sum(input sys_pkg::sample_t core, input sys_pkg::sample_t alsa,
			input logic sgn);
		int c;
		if (sgn)
			c = int'($signed(core));
		else
			c = int'(core >> 1);
		return c + int'($signed(alsa));
	endfunction

	function automatic sys_pkg::sample_t mix_ref(input int own, input int other,
			input sys_pkg::mix_mode_t mode, input sys_pkg::att_t att);
		int pre;
		int v;
		pre = other >>> 1;
		case (mode)
			2'd0: v = own;
			2'd1: v = own - (own >>> 3) + (pre >>> 2);
			2'd2: v = own - (own >>> 2) + (pre >>> 1);
			default: v = (own >>> 1) + pre;
		endcase
		if (att[4])
			v = 0;
		else
			v = v >>> att[3:0];
		if (v > 32767)
			v = 32767;
		else if (v < -32768)
			v = -32768;
		return 16'(v);
	endfunction

	// Overtake state where the mask bit is set and core LED elsewhere
	function automatic sys_pkg::led_t led_ref(input sys_pkg::led_t mask,
			input sys_pkg::led_t state, input sys_pkg::led_t core);
		sys_pkg::led_t v;
		for (int b = 0; b < 8; b++) begin
			if (mask[b])
				v[b] = state[b];
			else
				v[b] = core[b];
		end
		return v;
	endfunction

	task automatic expect_window();
		int wcalc;
		int hcalc;
		int videow;
		int videoh;
		int hmin;
		int vmin;
		// Zero aspect shows the whole frame
		hmin = 0;
		vmin = 0;
		videow = m_width;
		videoh = m_height;
		if (row.arx != 8'd0 && row.ary != 8'd0) begin
			wcalc = ((m_vset != 0) ? m_vset : m_height) * int'(row.arx) / int'(row.ary);
			hcalc = m_width * int'(row.ary) / int'(row.arx);
			videow = (m_vset == 0 && wcalc > m_width) ? m_width : wcalc;
			if (m_vset != 0)
				videoh = m_vset;
			else
				videoh = (hcalc < m_height) ? hcalc : m_height;
			hmin = (m_width - videow) / 2;
			vmin = (m_height - videoh) / 2;
		end
		row.hmin = 12'(hmin);
		row.hmax = 12'(hmin + videow - 1);
		row.vmin = 12'(vmin);
		row.vmax = 12'(vmin + videoh - 1);
	endtask

	// Runs word_q through the decoder model, then stores the row
	task automatic add_test(input string name, input int brk);
		sys_pkg::cmd_t cmd;
		int k;
		int sum_l;
		int sum_r;
		cmd = '0;
		k = 0;
		row.words = '0;
		row.nw = 4'(word_q.size());
		row.brk = 4'(brk);
		foreach (word_q[i]) begin
			row.words[i] = word_q[i];
			if (i == 0 || i == brk) begin
				cmd = word_q[i][7:0];
				k = 0;
			end else begin
				case (cmd)
					// Only WIDTH and HEIGHT reach the window and later words drop out
					sys_pkg::CMD_TIMING: begin
						if (k == 0)
							m_width = int'(word_q[i][11:0]);
						if (k == 4)
							m_height = int'(word_q[i][11:0]);
					end
					sys_pkg::CMD_LED: begin
						m_mask = word_q[i][15:8];
						m_state = word_q[i][7:0];
					end
					sys_pkg::CMD_VOLUME: m_att = word_q[i][4:0];
					sys_pkg::CMD_VSET: m_vset = int'(word_q[i][11:0]);
					default: ;
				endcase
				k++;
			end
		end
		expect_window();
		row.led = led_ref(m_mask, m_state, row.led_core);
		sum_l = conv_sum(row.core_l, row.alsa_l, row.sgn);
		sum_r = conv_sum(row.core_r, row.alsa_r, row.sgn);
		row.out_l = mix_ref(sum_l, sum_r, row.mix, m_att);
		row.out_r = mix_ref(sum_r, sum_l, row.mix, m_att);
		table_q.push_back(row);
		name_q.push_back(name);
	endtask

	task automatic random_audio();
		row.core_l = 16'($random(seed));
		row.core_r = 16'($random(seed));
		row.alsa_l = 16'($random(seed));
		row.alsa_r = 16'($random(seed));
	endtask

	//////////////////////////////
	// Drive and check
	//////////////////////////////

	// One select window with three clocks per strobe level
	task automatic send_frame(input test_row_t r, input int first, input int count);
		int k;
		@(negedge clk_sys);
		i_io_uio = 1'b1;
		for (k = 0; k < count; k++) begin
			i_io_din = r.words[first + k];
			i_io_strobe = 1'b1;
			repeat (3) @(negedge clk_sys);
			i_io_strobe = 1'b0;
			repeat (3) @(negedge clk_sys);
		end
		i_io_uio = 1'b0;
		repeat (3) @(negedge clk_sys);
	endtask

	task automatic apply_row(input test_row_t r);
		@(negedge clk_sys);
		i_arx = r.arx;
		i_ary = r.ary;
		i_led_core = r.led_core;
		i_audio_l = r.core_l;
		i_audio_r = r.core_r;
		i_alsa_l = r.alsa_l;
		i_alsa_r = r.alsa_r;
		i_audio_mix = r.mix;
		i_audio_signed = r.sgn;
		if (r.brk != 4'd0) begin
			send_frame(r, 0, int'(r.brk));
			send_frame(r, int'(r.brk), int'(r.nw - r.brk));
		end else if (r.nw != 4'd0) begin
			send_frame(r, 0, int'(r.nw));
		end
	endtask

	function automatic logic outputs_match(input test_row_t r);
		return (o_hmin == r.hmin) && (o_hmax == r.hmax) && (o_vmin == r.vmin) &&
			(o_vmax == r.vmax) && (o_led == r.led) && (o_audio_l == r.out_l) &&
			(o_audio_r == r.out_r);
	endfunction

	task automatic check_value(input string test, input string what,
			input logic [15:0] exp, input logic [15:0] act);
		assert (act === exp) else begin
			$display("** Error %s: %s expected 0x%04h, actual 0x%04h", test, what, exp, act);
			fail_cnt++;
		end
	endtask

	task automatic check_row(input test_row_t r, input string name);
		int n;
		int errs_before;
		n = 0;
		errs_before = fail_cnt;
		do begin
			@(negedge clk_sys);
			n++;
		end while (n < 40 && !outputs_match(r));
		if (!outputs_match(r)) begin
			$display("%s: outputs did not reach their expected values within 40 cycles", name);
			fail_cnt++;
		end
		check_value(name, "o_hmin", 16'(r.hmin), 16'(o_hmin));
		check_value(name, "o_hmax", 16'(r.hmax), 16'(o_hmax));
		check_value(name, "o_vmin", 16'(r.vmin), 16'(o_vmin));
		check_value(name, "o_vmax", 16'(r.vmax), 16'(o_vmax));
		check_value(name, "o_led", 16'(r.led), 16'(o_led));
		check_value(name, "o_audio_l", r.out_l, o_audio_l);
		check_value(name, "o_audio_r", r.out_r, o_audio_r);
		if (fail_cnt == errs_before) begin
			$display("%s passed", name);
		end else begin
			$display("%s failed", name);
			bad_tests++;
		end
	endtask

	initial begin
		int m;
		int s;
		resetd = 1'b1;
		i_io_uio = 1'b0;
		i_io_strobe = 1'b0;
		i_io_din = '0;
		i_arx = '0;
		i_ary = '0;
		i_led_core = '0;
		i_audio_l = '0;
		i_audio_r = '0;
		i_alsa_l = '0;
		i_alsa_r = '0;
		i_audio_signed = 1'b0;
		i_audio_mix = '0;

		// Power-on frame without an aspect ratio
		row = '0;
		row.led_core = 8'h5a;
		word_q.delete();
		add_test("reset_full_frame", 0);
		// Two extra words after the eight timing values
		row.arx = 8'd4;
		row.ary = 8'd3;
		word_q = '{16'h0020, 16'd1600, 16'd48, 16'd32, 16'd80, 16'd900, 16'd3, 16'd5,
			16'd23, 16'h0fff, 16'h0abc};
		add_test("timing_aspect_4_3", 0);
		word_q = '{16'h0027, 16'd720};
		add_test("vset_720", 0);
		// Deselecting after the LED word makes 0x27 a new command
		row.led_core = 8'h3c;
		word_q = '{16'h0025, 16'hf0a5, 16'h0027, 16'd720};
		add_test("led_overtake_reselect", 2);

		word_q.delete();
		for (m = 0; m < 4; m++) begin
			for (s = 0; s < 2; s++) begin
				random_audio();
				row.mix = 2'(m);
				row.sgn = (s == 1);
				add_test($sformatf("audio_mix%0d_sgn%0d", m, s), 0);
			end
		end
		row.core_l = 16'h7fff;
		row.alsa_l = 16'h7fff;
		row.core_r = 16'h8000;
		row.alsa_r = 16'h8000;
		row.mix = 2'd0;
		row.sgn = 1'b1;
		add_test("audio_clamp_full_scale", 0);
		random_audio();
		row.mix = 2'd1;
		word_q = '{16'h0026, 16'h0010};
		add_test("volume_mute", 0);
		random_audio();
		// Negative left sum so the shift has to keep the sign
		row.core_l = 16'h9000;
		row.alsa_l = 16'hc000;
		row.mix = 2'd2;
		word_q = '{16'h0026, 16'h0003};
		add_test("volume_shift_3", 0);

		repeat (16) @(negedge clk_sys);
		resetd = 1'b0;

		foreach (table_q[t]) begin
			apply_row(table_q[t]);
			check_row(table_q[t], name_q[t]);
		end

		$display("Tests run %0d, failed %0d, errors %0d", table_q.size(), bad_tests, fail_cnt);
		if (fail_cnt == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== logic/audio_mix_channel.sv ====
// One channel of the audio mixer
// Core audio stability filter, format conversion, Linux audio sum,
// crossfeed with the other channel, attenuation and 16-bit clamp

`timescale 1ns/1ps
`default_nettype none

module audio_mix_channel (
	input  wire                 clk_sys,
	input  wire                 resetd,

	input  sys_pkg::att_t       i_att,
	input  sys_pkg::mix_mode_t  i_mix,
	input  wire                 i_signed,

	input  sys_pkg::sample_t    i_core,
	input  sys_pkg::sample_t    i_linux,
	input  sys_pkg::sample_t    i_pre,

	output sys_pkg::sample_t    o_pre,
	output sys_pkg::sample_t    o_out
);

	sys_pkg::sample_t   core_d;
	sys_pkg::sample_t   core_ok;

	logic signed [16:0] conv;
	logic signed [16:0] pre_ext;
	logic signed [16:0] a2;
	logic signed [16:0] a3;
	logic signed [16:0] a4;

	// Sample only passes once seen twice in a row
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			core_d  <= '0;
			core_ok <= '0;
		end else begin
			core_d <= i_core;
			if (i_core == core_d)
				core_ok <= core_d;
		end
	end

	// Unsigned samples lose one bit to stay positive in 17 bits
	assign conv    = i_signed ? {core_ok[15], core_ok} : {2'b00, core_ok[15:1]};
	assign pre_ext = {i_pre[15], i_pre};

	//////////////////////////////
	// Arithmetic pipeline
	//////////////////////////////

	always_ff @(posedge clk_sys) begin
		a2 <= conv + $signed({i_linux[15], i_linux});

		case (i_mix)
			2'd0: a3 <= a2;
			2'd1: a3 <= a2 - (a2 >>> 3) + (pre_ext >>> 2);
			2'd2: a3 <= a2 - (a2 >>> 2) + (pre_ext >>> 1);
			default: a3 <= (a2 >>> 1) + pre_ext;
		endcase

		a4 <= i_att[4] ? 17'sd0 : (a3 >>> i_att[3:0]);
	end

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			o_pre <= '0;
			o_out <= '0;
		end else begin
			// Half of this channel feeds the other side
			o_pre <= a2[16:1];
			// Saturate when bits 16 and 15 disagree
			o_out <= (a4[16] ^ a4[15]) ? {a4[16], {15{a4[15]}}} : a4[15:0];
		end
	end

	a_mute: assert property (@(posedge clk_sys) disable iff (resetd)
		i_att[4] |-> ##2 (o_out == '0));

endmodule

`default_nettype wire

// ==== logic/sys_core_top.sv ====
// System shell core top level
// Command decoder, display window calculator and the two cross-fed
// audio mixer channels on the system clock

`timescale 1ns/1ps
`default_nettype none

module sys_core_top #(
	parameter sys_pkg::timing_t DEFAULT_WIDTH  = 12'd1920,
	parameter sys_pkg::timing_t DEFAULT_HFP    = 12'd88,
	parameter sys_pkg::timing_t DEFAULT_HS     = 12'd48,
	parameter sys_pkg::timing_t DEFAULT_HBP    = 12'd148,
	parameter sys_pkg::timing_t DEFAULT_HEIGHT = 12'd1080,
	parameter sys_pkg::timing_t DEFAULT_VFP    = 12'd4,
	parameter sys_pkg::timing_t DEFAULT_VS     = 12'd5,
	parameter sys_pkg::timing_t DEFAULT_VBP    = 12'd36
) (
	input  wire                 clk_sys,
	input  wire                 resetd,

	input  wire                 i_io_uio,
	input  wire                 i_io_strobe,
	input  sys_pkg::io_word_t   i_io_din,

	input  sys_pkg::aspect_t    i_arx,
	input  sys_pkg::aspect_t    i_ary,
	input  sys_pkg::led_t       i_led_core,

	input  sys_pkg::sample_t    i_audio_l,
	input  sys_pkg::sample_t    i_audio_r,
	input  sys_pkg::sample_t    i_alsa_l,
	input  sys_pkg::sample_t    i_alsa_r,
	input  wire                 i_audio_signed,
	input  sys_pkg::mix_mode_t  i_audio_mix,

	output sys_pkg::timing_t    o_hmin,
	output sys_pkg::timing_t    o_hmax,
	output sys_pkg::timing_t    o_vmin,
	output sys_pkg::timing_t    o_vmax,
	output sys_pkg::led_t       o_led,
	output sys_pkg::sample_t    o_audio_l,
	output sys_pkg::sample_t    o_audio_r
);

	sys_pkg::timing_t width;
	sys_pkg::timing_t height;
	sys_pkg::timing_t vset;
	sys_pkg::att_t    att;
	sys_pkg::sample_t pre_l;
	sys_pkg::sample_t pre_r;

	//////////////////////////////
	// Command and video
	//////////////////////////////

	uio_cmd_decoder #(
		.DEFAULT_WIDTH  (DEFAULT_WIDTH),
		.DEFAULT_HFP    (DEFAULT_HFP),
		.DEFAULT_HS     (DEFAULT_HS),
		.DEFAULT_HBP    (DEFAULT_HBP),
		.DEFAULT_HEIGHT (DEFAULT_HEIGHT),
		.DEFAULT_VFP    (DEFAULT_VFP),
		.DEFAULT_VS     (DEFAULT_VS),
		.DEFAULT_VBP    (DEFAULT_VBP)
	) cmd_i (
		.clk_sys     (clk_sys),
		.resetd      (resetd),
		.i_io_uio    (i_io_uio),
		.i_io_strobe (i_io_strobe),
		.i_io_din    (i_io_din),
		.i_led_core  (i_led_core),
		.o_width     (width),
		.o_height    (height),
		.o_vset      (vset),
		.o_att       (att),
		.o_led       (o_led)
	);

	video_window_calc win_i (
		.clk_sys  (clk_sys),
		.resetd   (resetd),
		.i_width  (width),
		.i_height (height),
		.i_vset   (vset),
		.i_arx    (i_arx),
		.i_ary    (i_ary),
		.o_hmin   (o_hmin),
		.o_hmax   (o_hmax),
		.o_vmin   (o_vmin),
		.o_vmax   (o_vmax)
	);

	//////////////////////////////
	// Audio
	//////////////////////////////

	// Each side takes the other's pre-mix half for crossfeed
	audio_mix_channel mix_l_i (
		.clk_sys  (clk_sys),
		.resetd   (resetd),
		.i_att    (att),
		.i_mix    (i_audio_mix),
		.i_signed (i_audio_signed),
		.i_core   (i_audio_l),
		.i_linux  (i_alsa_l),
		.i_pre    (pre_r),
		.o_pre    (pre_l),
		.o_out    (o_audio_l)
	);

	audio_mix_channel mix_r_i (
		.clk_sys  (clk_sys),
		.resetd   (resetd),
		.i_att    (att),
		.i_mix    (i_audio_mix),
		.i_signed (i_audio_signed),
		.i_core   (i_audio_r),
		.i_linux  (i_alsa_r),
		.i_pre    (pre_l),
		.o_pre    (pre_r),
		.o_out    (o_audio_r)
	);

endmodule

`default_nettype wire

// ==== logic/sys_pkg.sv ====
// Shared definitions for the system shell core
// Widths of the timing, user-I/O and audio paths, the user-I/O command
// codes and the window sequencer phases

`default_nettype none

package sys_pkg;

	//////////////////////////////
	// Data widths
	//////////////////////////////

	// Video timing value or display window bound
	typedef logic [11:0] timing_t;

	// User-I/O bus word and command code
	typedef logic [15:0] io_word_t;
	typedef logic [7:0]  cmd_t;

	// Aspect ratio as reported by the core
	typedef logic [7:0]  aspect_t;

	// Audio sample, attenuation (mute + shift) and crossfeed mode
	typedef logic [15:0] sample_t;
	typedef logic [4:0]  att_t;
	typedef logic [1:0]  mix_mode_t;

	typedef logic [7:0]  led_t;

	//////////////////////////////
	// User-I/O commands
	//////////////////////////////

	localparam cmd_t CMD_TIMING   = 8'h20;
	localparam cmd_t CMD_LED      = 8'h25;
	localparam cmd_t CMD_VOLUME   = 8'h26;
	localparam cmd_t CMD_VSET     = 8'h27;
	// Number of data words taken by CMD_TIMING
	localparam cmd_t TIMING_WORDS = 8'd8;

	// Window calculator sequence, one phase per clock
	typedef enum logic [2:0] {
		WIN_DIV,
		WIN_WAIT1,
		WIN_WAIT2,
		WIN_WAIT3,
		WIN_WAIT4,
		WIN_WAIT5,
		WIN_SIZE,
		WIN_CENTRE
	} win_phase_e;

endpackage

`default_nettype wire

// ==== logic/uio_cmd_decoder.sv ====
// User-I/O command decoder
// Takes one word per rising strobe edge while the channel is selected. The
// first word is the command, the rest are its data. Holds the video timing,
// volume, forced vertical size and LED overtake registers

`timescale 1ns/1ps
`default_nettype none

module uio_cmd_decoder #(
	parameter sys_pkg::timing_t DEFAULT_WIDTH  = 12'd1920,
	parameter sys_pkg::timing_t DEFAULT_HFP    = 12'd88,
	parameter sys_pkg::timing_t DEFAULT_HS     = 12'd48,
	parameter sys_pkg::timing_t DEFAULT_HBP    = 12'd148,
	parameter sys_pkg::timing_t DEFAULT_HEIGHT = 12'd1080,
	parameter sys_pkg::timing_t DEFAULT_VFP    = 12'd4,
	parameter sys_pkg::timing_t DEFAULT_VS     = 12'd5,
	parameter sys_pkg::timing_t DEFAULT_VBP    = 12'd36
) (
	input  wire                 clk_sys,
	input  wire                 resetd,

	input  wire                 i_io_uio,
	input  wire                 i_io_strobe,
	input  sys_pkg::io_word_t   i_io_din,
	input  sys_pkg::led_t       i_led_core,

	output sys_pkg::timing_t    o_width,
	output sys_pkg::timing_t    o_height,
	output sys_pkg::timing_t    o_vset,
	output sys_pkg::att_t       o_att,
	output sys_pkg::led_t       o_led
);

	logic             strobe_d;
	logic             strobe_rise;
	logic             has_cmd;
	sys_pkg::cmd_t    cmd;
	logic [3:0]       word_cnt;

	// WIDTH, HFP, HS, HBP, HEIGHT, VFP, VS, VBP in command order
	sys_pkg::timing_t timing_r [8];

	sys_pkg::att_t    att_r;
	sys_pkg::timing_t vset_r;
	sys_pkg::led_t    led_mask;
	sys_pkg::led_t    led_state;

	assign strobe_rise = i_io_strobe & ~strobe_d;

	//////////////////////////////
	// Command parser
	//////////////////////////////

	always_ff @(posedge clk_sys) begin
		strobe_d <= i_io_strobe;

		if (resetd) begin
			strobe_d    <= 1'b0;
			has_cmd     <= 1'b0;
			cmd         <= '0;
			word_cnt    <= '0;
			att_r       <= '0;
			vset_r      <= '0;
			led_mask    <= '0;
			timing_r[0] <= DEFAULT_WIDTH;
			timing_r[1] <= DEFAULT_HFP;
			timing_r[2] <= DEFAULT_HS;
			timing_r[3] <= DEFAULT_HBP;
			timing_r[4] <= DEFAULT_HEIGHT;
			timing_r[5] <= DEFAULT_VFP;
			timing_r[6] <= DEFAULT_VS;
			timing_r[7] <= DEFAULT_VBP;
		end else if (!i_io_uio) begin
			// Channel deselected, next word is a command again
			has_cmd <= 1'b0;
			cmd     <= '0;
		end else if (strobe_rise) begin
			if (!has_cmd) begin
				has_cmd  <= 1'b1;
				cmd      <= i_io_din[7:0];
				word_cnt <= '0;
			end else begin
				case (cmd)
					sys_pkg::CMD_TIMING: begin
						// Words past the eighth are dropped
						if (word_cnt < 4'(sys_pkg::TIMING_WORDS)) begin
							timing_r[word_cnt[2:0]] <= i_io_din[11:0];
							word_cnt <= word_cnt + 4'd1;
						end
					end
					sys_pkg::CMD_LED:    led_mask <= i_io_din[15:8];
					sys_pkg::CMD_VOLUME: att_r    <= i_io_din[4:0];
					sys_pkg::CMD_VSET:   vset_r   <= i_io_din[11:0];
					default: ;
				endcase
			end
		end
	end

	// LED state is only visible where the mask is set
	always_ff @(posedge clk_sys) begin
		if (i_io_uio && strobe_rise && has_cmd && cmd == sys_pkg::CMD_LED) begin
			led_state <= i_io_din[7:0];
		end
	end

	//////////////////////////////
	// Outputs
	//////////////////////////////

	assign o_width  = timing_r[0];
	assign o_height = timing_r[4];
	assign o_vset   = vset_r;
	assign o_att    = att_r;

	// Main board LEDs, overtaken bit by bit
	assign o_led = (led_mask & led_state) | (~led_mask & i_led_core);

	// Timing data never runs past the eight timing registers
	a_timing_cnt: assert property (@(posedge clk_sys) disable iff (resetd)
		(has_cmd && cmd == sys_pkg::CMD_TIMING)
			|-> word_cnt <= 4'(sys_pkg::TIMING_WORDS));

endmodule

`default_nettype wire

// ==== logic/video_window_calc.sv ====
// Aspect-ratio display window calculator
// Eight-phase loop. Divides in the first phase, gives the divider five
// spare cycles, picks the video size and then centres it in the frame

`timescale 1ns/1ps
`default_nettype none

module video_window_calc (
	input  wire                 clk_sys,
	input  wire                 resetd,

	input  sys_pkg::timing_t    i_width,
	input  sys_pkg::timing_t    i_height,
	input  sys_pkg::timing_t    i_vset,
	input  sys_pkg::aspect_t    i_arx,
	input  sys_pkg::aspect_t    i_ary,

	output sys_pkg::timing_t    o_hmin,
	output sys_pkg::timing_t    o_hmax,
	output sys_pkg::timing_t    o_vmin,
	output sys_pkg::timing_t    o_vmax
);

	sys_pkg::win_phase_e phase;
	logic                pass_done;

	logic [19:0]         wcalc;
	logic [19:0]         hcalc;
	sys_pkg::timing_t    vsrc;
	sys_pkg::timing_t    videow;
	sys_pkg::timing_t    videoh;
	sys_pkg::timing_t    hoff;
	sys_pkg::timing_t    voff;

	// Forced vertical size wins over the frame height
	assign vsrc = (i_vset != '0) ? i_vset : i_height;

	assign hoff = (i_width - videow) >> 1;
	assign voff = (i_height - videoh) >> 1;

	// Divisions are given six cycles to settle before WIN_SIZE
	always_ff @(posedge clk_sys) begin
		if (phase == sys_pkg::WIN_DIV) begin
			wcalc <= (20'(vsrc) * 20'(i_arx)) / 20'(i_ary);
			hcalc <= (20'(i_width) * 20'(i_ary)) / 20'(i_arx);
		end
		if (phase == sys_pkg::WIN_SIZE) begin
			videow <= ((i_vset == '0) && (wcalc > 20'(i_width))) ? i_width : wcalc[11:0];
			if (i_vset != '0)
				videoh <= i_vset;
			else
				videoh <= (hcalc > 20'(i_height)) ? i_height : hcalc[11:0];
		end
	end

	//////////////////////////////
	// Phase sequencer
	//////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			phase     <= sys_pkg::WIN_DIV;
			pass_done <= 1'b0;
			o_hmin    <= '0;
			o_hmax    <= '0;
			o_vmin    <= '0;
			o_vmax    <= '0;
		end else if (i_arx == '0 || i_ary == '0) begin
			// No aspect ratio, show the whole frame
			phase     <= sys_pkg::WIN_DIV;
			pass_done <= 1'b1;
			o_hmin    <= '0;
			o_hmax    <= i_width - 12'd1;
			o_vmin    <= '0;
			o_vmax    <= i_height - 12'd1;
		end else begin
			phase <= sys_pkg::win_phase_e'(phase + 3'd1);
			if (phase == sys_pkg::WIN_CENTRE) begin
				pass_done <= 1'b1;
				o_hmin    <= hoff;
				o_hmax    <= hoff + videow - 12'd1;
				o_vmin    <= voff;
				o_vmax    <= voff + videoh - 12'd1;
			end
		end
	end

	// Once a window has been written, it is never inverted
	a_window_order: assert property (@(posedge clk_sys) disable iff (resetd)
		pass_done |-> o_hmax >= o_hmin);

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the system shell core testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f verilog.f --top-module sys_core_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator build did not complete"
	exit 1
fi

sim_out=$(./obj_dir/Vsys_core_tb)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if echo "$sim_out" | grep -qx "Test OK"; then
	exit 0
else
	echo "Pass message not found in simulation output"
	exit 1
fi

// ==== verilog.f ====
logic/sys_pkg.sv
logic/uio_cmd_decoder.sv
logic/video_window_calc.sv
logic/audio_mix_channel.sv
logic/sys_core_top.sv
dv/sys_core_tb.sv
